// File: build.f
+incdir+.
ps2_pkg.sv
ps2_frame_rx.sv
ps2_key_filter.sv
scan_fifo.sv
scan_to_ascii.sv
seg_display.sv
ps2_keyboard_top.sv
tb_ps2_keyboard.sv

// File: ps2_frame_rx.sv
`include "ps2_params.svh"

module ps2_frame_rx
    import ps2_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       ps2_clk,
    input  logic       ps2_data,
    output ps2_frame_t frame,
    output logic       frame_valid,
    output logic       frame_bad
);

    localparam int SYNC_N = `PS2_SYNC_STAGES;

    logic [SYNC_N-1:0] clk_sync;
    logic [SYNC_N-1:0] data_sync;
    logic              ps2_fall;
    logic              ps2_bit;
    rx_state_e         state;
    logic [2:0]        bit_cnt;
    logic [7:0]        shift;
    logic              parity_ok;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Input synchronizers, both lines idle high
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            clk_sync  <= '1;
            data_sync <= '1;
        end else begin
            clk_sync  <= {clk_sync[SYNC_N-2:0], ps2_clk};
            data_sync <= {data_sync[SYNC_N-2:0], ps2_data};
        end
    end

    // The last stage only serves the edge detector
    assign ps2_fall = clk_sync[SYNC_N-1] & ~clk_sync[SYNC_N-2];
    assign ps2_bit  = data_sync[SYNC_N-2];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Frame state machine, one step per falling PS/2 clock edge
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= RX_IDLE;
            bit_cnt     <= '0;
            parity_ok   <= 1'b0;
            frame_valid <= 1'b0;
            frame_bad   <= 1'b0;
        end else begin
            frame_valid <= 1'b0;
            frame_bad   <= 1'b0;
            if (ps2_fall) begin
                case (state)
                    RX_IDLE: begin
                        if (!ps2_bit) begin
                            state   <= RX_DATA;
                            bit_cnt <= '0;
                        end else begin
                            frame_bad <= 1'b1;
                        end
                    end
                    RX_DATA: begin
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            state <= RX_PARITY;
                        end
                    end
                    RX_PARITY: begin
                        // Odd parity over data and parity bit
                        parity_ok <= ^{shift, ps2_bit};
                        state     <= RX_STOP;
                    end
                    RX_STOP: begin
                        state <= RX_IDLE;
                        if (ps2_bit && parity_ok) begin
                            frame_valid <= 1'b1;
                        end else begin
                            frame_bad <= 1'b1;
                        end
                    end
                    default: state <= RX_IDLE;
                endcase
            end
        end
    end

    // Data arrives least significant bit first
    always_ff @(posedge clk) begin
        if (ps2_fall && state == RX_DATA) begin
            shift <= {ps2_bit, shift[7:1]};
        end
        if (ps2_fall && state == RX_STOP) begin
            frame.data      <= shift;
            frame.parity_ok <= parity_ok;
        end
    end

    a_valid_bad_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n) !(frame_valid && frame_bad));

    a_result_one_cycle: assert property (
        @(posedge clk) disable iff (!rst_n)
        (frame_valid || frame_bad) |=> !(frame_valid || frame_bad));

endmodule

// File: ps2_key_filter.sv
`include "ps2_params.svh"

module ps2_key_filter
    import ps2_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  ps2_frame_t frame,
    input  logic       frame_valid,
    output logic       push,
    output logic [7:0] push_code,
    output logic       key_held,
    output logic [7:0] press_count
);

    logic       byte_ok;
    logic       is_break;
    logic       take;
    logic       release_armed;
    logic [7:0] last_byte;

    assign byte_ok  = frame_valid && frame.parity_ok;
    assign is_break = frame.data == `PS2_BREAK_CODE;
    assign take     = byte_ok && !is_break && !release_armed;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            release_armed <= 1'b0;
            key_held      <= 1'b0;
            push          <= 1'b0;
            press_count   <= '0;
            last_byte     <= '0;
        end else begin
            push <= take;
            if (byte_ok && is_break) begin
                release_armed <= 1'b1;
                key_held      <= 1'b0;
                last_byte     <= frame.data;
            end else if (byte_ok && release_armed) begin
                // The released key's code is dropped and leaves last_byte alone
                release_armed <= 1'b0;
            end else if (take) begin
                key_held  <= 1'b1;
                last_byte <= frame.data;
                // A typematic repeat repeats the previous byte exactly
                if (frame.data != last_byte) begin
                    if (press_count == 8'(`PS2_COUNT_MOD - 1)) begin
                        press_count <= '0;
                    end else begin
                        press_count <= press_count + 8'd1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            push_code <= frame.data;
        end
    end

endmodule

// File: ps2_keyboard_top.sv
`include "ps2_params.svh"

module ps2_keyboard_top
    import ps2_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       ps2_clk,
    input  logic       ps2_data,
    input  logic       key_ack,
    output key_entry_t key,
    output logic       key_req,
    output logic       overflow,
    output logic       frame_error,
    output seg_bank_t  segs
);

    ps2_frame_t frame;
    logic       frame_valid;
    logic       frame_bad;
    logic       push;
    logic [7:0] push_code;
    logic       key_held;
    logic [7:0] press_count;
    logic [7:0] head_code;
    logic [7:0] ascii;

    ps2_frame_rx i_frame_rx (
        .clk         (clk),
        .rst_n       (rst_n),
        .ps2_clk     (ps2_clk),
        .ps2_data    (ps2_data),
        .frame       (frame),
        .frame_valid (frame_valid),
        .frame_bad   (frame_bad)
    );

    ps2_key_filter i_key_filter (
        .clk         (clk),
        .rst_n       (rst_n),
        .frame       (frame),
        .frame_valid (frame_valid),
        .push        (push),
        .push_code   (push_code),
        .key_held    (key_held),
        .press_count (press_count)
    );

    scan_fifo i_scan_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (push),
        .push_code (push_code),
        .head_code (head_code),
        .key_req   (key_req),
        .key_ack   (key_ack),
        .overflow  (overflow)
    );

    // Decodes the queue head, so the ASCII half follows every pop
    scan_to_ascii i_scan_to_ascii (
        .code  (head_code),
        .ascii (ascii)
    );

    seg_display i_seg_display (
        .head_code   (head_code),
        .ascii       (ascii),
        .press_count (press_count),
        .key_held    (key_held),
        .show_head   (key_req),
        .segs        (segs)
    );

    assign key = '{code: head_code, ascii: ascii};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            frame_error <= 1'b0;
        end else if (frame_bad) begin
            frame_error <= 1'b1;
        end
    end

endmodule

// File: ps2_params.svh
`ifndef PS2_PARAMS_SVH
`define PS2_PARAMS_SVH

// Scan-code queue entries, must be a power of two
`define PS2_FIFO_DEPTH 8

// Flip-flops on the PS/2 clock and data lines, at least two
`define PS2_SYNC_STAGES 3

// The press counter wraps to zero here
`define PS2_COUNT_MOD 100

// Set-2 break prefix sent ahead of a released key's code
`define PS2_BREAK_CODE 8'hF0

`endif

// File: ps2_pkg.sv
`include "ps2_params.svh"

package ps2_pkg;

    // Queue pointers carry one extra bit to tell full from empty
    localparam int PS2_PTR_W = $clog2(`PS2_FIFO_DEPTH) + 1;

    typedef logic [PS2_PTR_W-1:0] fifo_ptr_t;

    typedef struct packed {
        logic [7:0] data;
        logic       parity_ok;
    } ps2_frame_t;

    typedef struct packed {
        logic [7:0] code;
        logic [7:0] ascii;
    } key_entry_t;

    // Active-low patterns, segment a in bit 6, digit 0 first
    typedef struct packed {
        logic [6:0] hex_lo;
        logic [6:0] hex_hi;
        logic [6:0] asc_ones;
        logic [6:0] asc_tens;
        logic [6:0] cnt_ones;
        logic [6:0] cnt_tens;
    } seg_bank_t;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_DATA,
        RX_PARITY,
        RX_STOP
    } rx_state_e;

endpackage

// File: ps2_testdata.txt
# Columns in hex: scan code, corrupt-parity flag, expected ASCII
# The last ten lines are sent while the host holds off
1C 0 41
F0 0 00
1C 0 41
1C 0 41
16 1 31
45 0 30
45 0 30
15 0 51
1D 0 57
24 0 45
2D 0 52
2C 0 54
35 0 59
3C 0 55
43 0 49
44 0 4F
4D 0 50

// File: scan_fifo.sv
`include "ps2_params.svh"

module scan_fifo
    import ps2_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       push,
    input  logic [7:0] push_code,
    output logic [7:0] head_code,
    output logic       key_req,
    input  logic       key_ack,
    output logic       overflow
);

    localparam int IDX_W = PS2_PTR_W - 1;

    typedef enum logic {
        HS_IDLE,
        HS_REQ
    } hs_state_e;

    logic [7:0] mem [`PS2_FIFO_DEPTH];
    fifo_ptr_t  wr_ptr;
    fifo_ptr_t  rd_ptr;
    logic       empty;
    logic       full;
    logic       wr_en;
    logic       pop;
    hs_state_e  hs_state;

    assign empty = wr_ptr == rd_ptr;
    assign full  = (wr_ptr[IDX_W] != rd_ptr[IDX_W])
                && (wr_ptr[IDX_W-1:0] == rd_ptr[IDX_W-1:0]);
    assign wr_en = push && !full;
    assign pop   = (hs_state == HS_REQ) && key_ack;

    assign key_req   = hs_state == HS_REQ;
    assign head_code = mem[rd_ptr[IDX_W-1:0]];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            overflow <= 1'b0;
            hs_state <= HS_IDLE;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (push && full) begin
                overflow <= 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case (hs_state)
                // A push into an empty queue raises the request right away
                HS_IDLE: if (!key_ack && (!empty || push)) hs_state <= HS_REQ;
                HS_REQ:  if (key_ack) hs_state <= HS_IDLE;
                default: hs_state <= HS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr[IDX_W-1:0]] <= push_code;
        end
    end

    a_req_holds: assert property (
        @(posedge clk) disable iff (!rst_n)
        (key_req && !key_ack) |=> (key_req && $stable(head_code)));

    // Occupancy stays within the buffer, so no write lands on a full queue
    a_no_overrun: assert property (
        @(posedge clk) disable iff (!rst_n)
        fifo_ptr_t'(wr_ptr - rd_ptr) <= fifo_ptr_t'(`PS2_FIFO_DEPTH));

endmodule

// File: scan_to_ascii.sv
module scan_to_ascii
    import ps2_pkg::*;
(
    input  logic [7:0] code,
    output logic [7:0] ascii
);

    // Set-2 make codes of the letter and digit keys
    always_comb begin
        case (code)
            8'h1C: ascii = "A";
            8'h32: ascii = "B";
            8'h21: ascii = "C";
            8'h23: ascii = "D";
            8'h24: ascii = "E";
            8'h2B: ascii = "F";
            8'h34: ascii = "G";
            8'h33: ascii = "H";
            8'h43: ascii = "I";
            8'h3B: ascii = "J";
            8'h42: ascii = "K";
            8'h4B: ascii = "L";
            8'h3A: ascii = "M";
            8'h31: ascii = "N";
            8'h44: ascii = "O";
            8'h4D: ascii = "P";
            8'h15: ascii = "Q";
            8'h2D: ascii = "R";
            8'h1B: ascii = "S";
            8'h2C: ascii = "T";
            8'h3C: ascii = "U";
            8'h2A: ascii = "V";
            8'h1D: ascii = "W";
            8'h22: ascii = "X";
            8'h35: ascii = "Y";
            8'h1A: ascii = "Z";
            8'h45: ascii = "0";
            8'h16: ascii = "1";
            8'h1E: ascii = "2";
            8'h26: ascii = "3";
            8'h25: ascii = "4";
            8'h2E: ascii = "5";
            8'h36: ascii = "6";
            8'h3D: ascii = "7";
            8'h3E: ascii = "8";
            8'h46: ascii = "9";
            default: ascii = 8'h00;
        endcase
    end

endmodule

// File: seg_display.sv
`include "ps2_params.svh"

module seg_display
    import ps2_pkg::*;
(
    input  logic [7:0] head_code,
    input  logic [7:0] ascii,
    input  logic [7:0] press_count,
    input  logic       key_held,
    input  logic       show_head,
    output seg_bank_t  segs
);

    localparam logic [6:0] BLANK = 7'h7F;

    logic       show;
    logic [3:0] asc_ones;
    logic [3:0] asc_tens;
    logic [3:0] cnt_ones;
    logic [3:0] cnt_tens;

    // Active low, bits are a b c d e f g
    function automatic logic [6:0] encode(input logic [3:0] nib);
        case (nib)
            4'h0: return 7'b0000001;
            4'h1: return 7'b1001111;
            4'h2: return 7'b0010010;
            4'h3: return 7'b0000110;
            4'h4: return 7'b1001100;
            4'h5: return 7'b0100100;
            4'h6: return 7'b0100000;
            4'h7: return 7'b0001111;
            4'h8: return 7'b0000000;
            4'h9: return 7'b0000100;
            4'hA: return 7'b0001000;
            4'hB: return 7'b1100000;
            4'hC: return 7'b0110001;
            4'hD: return 7'b1000010;
            4'hE: return 7'b0110000;
            default: return 7'b0111000;
        endcase
    endfunction

    assign show     = key_held && show_head;
    assign asc_ones = 4'(ascii % 8'd10);
    assign asc_tens = 4'((ascii / 8'd10) % 8'd10);
    assign cnt_ones = 4'(press_count % 8'd10);
    assign cnt_tens = 4'((press_count % 8'(`PS2_COUNT_MOD)) / 8'd10);

    assign segs.hex_lo   = show ? encode(head_code[3:0]) : BLANK;
    assign segs.hex_hi   = show ? encode(head_code[7:4]) : BLANK;
    assign segs.asc_ones = show ? encode(asc_ones) : BLANK;
    assign segs.asc_tens = show ? encode(asc_tens) : BLANK;
    assign segs.cnt_ones = encode(cnt_ones);
    assign segs.cnt_tens = encode(cnt_tens);

endmodule

// File: tb_ps2_keyboard.sv
`include "ps2_params.svh"

module tb_ps2_keyboard
    import ps2_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD  = 4;
    localparam int BIT_CYCLES  = 20;
    localparam int IDLE_CYCLES = 40;
    localparam int HOLD_FRAMES = 10;

    typedef struct packed {
        logic [7:0] code;
        logic       bad_parity;
        logic [7:0] ascii;
    } stim_t;

    logic        clk;
    logic        rst_n;
    logic        ps2_clk;
    logic        ps2_data;
    logic        key_ack;
    key_entry_t  key;
    logic        key_req;
    logic        overflow;
    logic        frame_error;
    seg_bank_t   segs;

    stim_t       stim_q[$];
    key_entry_t  exp_q[$];
    int          n_frames;
    logic        loaded;
    logic        host_hold;
    logic        host_busy;
    logic [15:0] lfsr;

    // Reference model of the filter
    logic        model_armed;
    logic        model_held;
    logic [7:0]  model_last;
    int          model_count;
    logic        model_ovf;
    logic        model_ferr;

    ps2_keyboard_top i_ps2_keyboard_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .ps2_clk     (ps2_clk),
        .ps2_data    (ps2_data),
        .key_ack     (key_ack),
        .key         (key),
        .key_req     (key_req),
        .overflow    (overflow),
        .frame_error (frame_error),
        .segs        (segs)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2);
            clk = ~clk;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Lit segments a..g with a as the top bit, then inverted for active low
    function automatic logic [6:0] seven_seg(input logic [3:0] nib);
        logic [6:0] lit;
        case (nib)
            4'h0: lit = 7'b1111110;
            4'h1: lit = 7'b0110000;
            4'h2: lit = 7'b1101101;
            4'h3: lit = 7'b1111001;
            4'h4: lit = 7'b0110011;
            4'h5: lit = 7'b1011011;
            4'h6: lit = 7'b1011111;
            4'h7: lit = 7'b1110000;
            4'h8: lit = 7'b1111111;
            4'h9: lit = 7'b1111011;
            4'hA: lit = 7'b1110111;
            4'hB: lit = 7'b0011111;
            4'hC: lit = 7'b1001110;
            4'hD: lit = 7'b0111101;
            4'hE: lit = 7'b1001111;
            default: lit = 7'b1000111;
        endcase
        return ~lit;
    endfunction

    // 16-bit Galois LFSR, polynomial x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 16'hB400;
        end
        return state >> 1;
    endfunction

    task automatic draw_delay(output int cycles);
        cycles = 0;
        for (int i = 0; i < 3; i++) begin
            cycles = (cycles << 1) | int'(lfsr[0]);
            lfsr = lfsr_step(lfsr);
        end
    endtask

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            report_failure($sformatf("FAIL %s: expected %0h, actual %0h",
                                     name, expected, actual));
        end
    endtask

    task automatic check_digits(input string name, input logic show, input key_entry_t e);
        logic [6:0] blank;
        blank = 7'h7F;
        check_value({name, " hex low"}, show ? seven_seg(e.code[3:0]) : blank, segs.hex_lo);
        check_value({name, " hex high"}, show ? seven_seg(e.code[7:4]) : blank, segs.hex_hi);
        check_value({name, " ascii ones"}, show ? seven_seg(4'(e.ascii % 10)) : blank,
                    segs.asc_ones);
        check_value({name, " ascii tens"}, show ? seven_seg(4'((e.ascii / 10) % 10)) : blank,
                    segs.asc_tens);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // PS/2 device side and reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Data changes while the PS/2 clock is high, the host samples on its fall
    task automatic drive_bit(input logic b);
        ps2_data <= b;
        repeat (BIT_CYCLES / 4) @(posedge clk);
        ps2_clk <= 1'b0;
        repeat (BIT_CYCLES / 2) @(posedge clk);
        ps2_clk <= 1'b1;
        repeat (BIT_CYCLES / 4) @(posedge clk);
    endtask

    task automatic send_frame(input stim_t s);
        logic parity;
        parity = ~^s.code;
        if (s.bad_parity) begin
            parity = ~parity;
        end
        drive_bit(1'b0);
        for (int i = 0; i < 8; i++) begin
            drive_bit(s.code[i]);
        end
        drive_bit(parity);
        drive_bit(1'b1);
        repeat (IDLE_CYCLES) @(posedge clk);
    endtask

    task automatic apply_model(input stim_t s);
        if (s.bad_parity) begin
            model_ferr = 1'b1;
        end else if (s.code == `PS2_BREAK_CODE) begin
            model_armed = 1'b1;
            model_held  = 1'b0;
            model_last  = s.code;
        end else if (model_armed) begin
            model_armed = 1'b0;
        end else begin
            model_held = 1'b1;
            if (s.code != model_last) begin
                model_count = (model_count + 1) % `PS2_COUNT_MOD;
            end
            model_last = s.code;
            if (exp_q.size() >= `PS2_FIFO_DEPTH) begin
                model_ovf = 1'b1;
            end else begin
                exp_q.push_back('{code: s.code, ascii: s.ascii});
            end
        end
    endtask

    // True for the make code ahead of a break, the break prefix and the released code
    function automatic logic around_break(input int idx);
        if (model_armed || stim_q[idx].code == `PS2_BREAK_CODE) begin
            return 1'b1;
        end
        if (idx + 1 < stim_q.size()) begin
            return stim_q[idx + 1].code == `PS2_BREAK_CODE;
        end
        return 1'b0;
    endfunction

    task automatic wait_drain();
        do begin
            @(posedge clk);
        end while (exp_q.size() != 0 || host_busy || key_req);
    endtask

    task automatic check_after_frame(input int idx);
        string      tag;
        key_entry_t head;
        logic       show;
        tag  = $sformatf("frame %0d", idx);
        head = (exp_q.size() > 0) ? exp_q[0] : '0;
        show = key_req && model_held && (exp_q.size() > 0);
        check_value({tag, " count ones"}, seven_seg(4'(model_count % 10)), segs.cnt_ones);
        check_value({tag, " count tens"}, seven_seg(4'(model_count / 10)), segs.cnt_tens);
        check_value({tag, " frame error"}, model_ferr, frame_error);
        check_value({tag, " overflow"}, model_ovf, overflow);
        check_digits(tag, show, head);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Host side of the four-phase handshake
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin : host_model
        key_entry_t head;
        int         delay;
        forever begin
            @(posedge clk);
            if (rst_n && key_req && !host_hold) begin
                if (exp_q.size() == 0) begin
                    report_failure($sformatf(
                        "Host port offered code %0h when no key was expected", key.code));
                end else begin
                    host_busy = 1'b1;
                    head = exp_q.pop_front();
                    check_value("host code", head.code, key.code);
                    check_value("host ascii", head.ascii, key.ascii);
                    check_digits("host", model_held, head);
                    draw_delay(delay);
                    repeat (delay) @(posedge clk);
                    key_ack <= 1'b1;
                    do begin
                        @(posedge clk);
                    end while (key_req);
                    key_ack <= 1'b0;
                    host_busy = 1'b0;
                end
            end
        end
    end

    initial begin : watchdog
        wait (loaded);
        #(n_frames * 11 * BIT_CYCLES * CLK_PERIOD * 3 / 2);
        report_failure("Timeout: the DUT stopped delivering keys before the run finished");
    end

    initial begin : stimulus
        int         fd;
        int         fields;
        string      line;
        logic [7:0] f_code;
        logic [7:0] f_flag;
        logic [7:0] f_ascii;

        rst_n       = 1'b0;
        ps2_clk     = 1'b1;
        ps2_data    = 1'b1;
        key_ack     = 1'b0;
        host_hold   = 1'b0;
        host_busy   = 1'b0;
        loaded      = 1'b0;
        lfsr        = 16'd10079;
        model_armed = 1'b0;
        model_held  = 1'b0;
        model_last  = 8'h00;
        model_count = 0;
        model_ovf   = 1'b0;
        model_ferr  = 1'b0;

        fd = $fopen("ps2_testdata.txt", "r");
        if (fd == 0) begin
            report_failure("Could not open ps2_testdata.txt for reading");
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) != 0) begin
                    fields = $sscanf(line, "%h %h %h", f_code, f_flag, f_ascii);
                    if (fields == 3) begin
                        stim_q.push_back('{code: f_code, bad_parity: f_flag[0],
                                           ascii: f_ascii});
                    end
                end
            end
            $fclose(fd);
            n_frames = stim_q.size();
            loaded   = 1'b1;

            repeat (16) @(posedge clk);
            rst_n <= 1'b1;
            repeat (4) @(posedge clk);

            // The last frames arrive while the host holds off and fill the queue
            // Around a break the host also holds off, so the head waits while no key is held
            foreach (stim_q[i]) begin
                host_hold = (i >= n_frames - HOLD_FRAMES) || around_break(i);
                if (!host_hold) begin
                    wait_drain();
                end
                apply_model(stim_q[i]);
                send_frame(stim_q[i]);
                if (!host_hold) begin
                    wait_drain();
                end
                check_after_frame(i);
            end

            host_hold = 1'b0;
            wait_drain();
            repeat (20) @(posedge clk);
            check_value("no extra delivery", 0, key_req);
            check_value("overflow after fill", 1, overflow);
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule
